/* verilog.f */
design/ulpi_rx_pkg.sv
design/ulpi_rx_fsm.sv
design/ulpi_frame_capture.sv
design/ulpi_frame_queue.sv
design/ulpi_credit_counter.sv
design/ulpi_rx_top.sv
tb/tb_ulpi_rx.sv

/* Makefile */
# Verilator build and run for the ULPI receive testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ulpi_rx
FILELIST = verilog.f
PASS_MSG = === PASS ===

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_ulpi_rx.sv */
// Testbench for the ULPI receive subsystem with LFSR bursts, consumer model and checks
module tb_ulpi_rx import ulpi_rx_pkg::*;;

    localparam int QUEUE_DEPTH = DEF_QUEUE_DEPTH;
    localparam int CREDITS     = DEF_CREDITS;

    logic       clk;
    logic       arst_n;
    logic       me;
    logic       dir;
    logic       nxt;
    logic [7:0] data;
    logic       credit_return;
    logic       frame_valid;
    logic [7:0] frame_cmd;
    logic [7:0] frame_pid;
    logic [7:0] frame_d1;
    logic [7:0] frame_d2;
    logic [7:0] drop_count;
    logic       busy;

    logic [31:0] lfsr_state = 32'hb9f4;
    ulpi_frame_t exp_q[$];      // Frames still to be delivered in arrival order
    int          pending[$];    // Cycle at which each held credit goes back
    int          exp_drops    = 0;
    int          outstanding  = 0;  // Frames delivered but not yet credited
    int          cycle        = 0;
    int          mismatch_err = 0;
    int          other_err    = 0;
    logic        hold_credits;  // Consumer withholds all returns
    logic        me_prev      = 1'b1;

    ulpi_rx_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .CREDITS     (CREDITS)
    ) i_ulpi_rx_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .me            (me),
        .dir           (dir),
        .nxt           (nxt),
        .data          (data),
        .credit_return (credit_return),
        .frame_valid   (frame_valid),
        .frame_cmd     (frame_cmd),
        .frame_pid     (frame_pid),
        .frame_d1      (frame_d1),
        .frame_d2      (frame_d2),
        .drop_count    (drop_count),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois step with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;  // Drive point
    endtask

    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            mismatch_err++;
            $display("MISMATCH t=%0t %s expected=%02h got=%02h", $time, name, exp, got);
        end
    endtask

    // Wait out the burst and give drop_count time to settle
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < 50) begin
            step();
            n++;
        end
        assert (!busy) else begin
            other_err++;
            $display("Timeout at %0t: receiver still busy after the burst", $time);
        end
        repeat (3) step();
    endtask

    // kind is 0 for good, 1 for early dir fall and 2 for wrong nxt
    task automatic send_burst(input int kind, input bit full_drop);
        logic [7:0]  b [5];
        int          bad_idx;
        ulpi_frame_t f;
        for (int i = 0; i < 5; i++) begin
            b[i] = 8'(take_bits(8));
        end
        bad_idx = take_bits(3) % 5;
        dir  = 1'b1;  // Turnaround
        nxt  = 1'b0;
        data = 8'h00;
        step();
        for (int i = 0; i < 5; i++) begin
            if (kind == 1 && i == bad_idx) break;
            data = b[i];
            nxt  = (i == 0 || i == 3) ? 1'b0 : 1'b1;  // Low for RX CMD and high for packet bytes
            if (kind == 2 && i == bad_idx) nxt = ~nxt;
            step();
        end
        if (kind == 0 && me) check_val("busy", 8'(busy), 8'd1);
        dir  = 1'b0;
        nxt  = 1'b0;
        data = 8'h00;
        // Record before the frame can reach frame_valid
        if (me) begin
            if (kind != 0 || full_drop) begin
                exp_drops++;
            end else begin
                f = '{cmd: b[3], pid: b[1], d1: b[2], d2: b[4]};  // Second RX CMD wins
                exp_q.push_back(f);
            end
        end
        wait_idle();
        check_val("drop_count", drop_count, 8'(exp_drops));
    endtask

    task automatic drain(input int limit);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || outstanding != 0) && n < limit) begin
            step();
            n++;
        end
        assert (exp_q.size() == 0 && outstanding == 0) else begin
            other_err++;
            $display("Timeout at %0t: %0d frames undelivered, %0d credits not returned",
                     $time, exp_q.size(), outstanding);
        end
    endtask

    // Consumer returns each credit after a random hold
    initial begin : consumer
        logic ret;
        forever begin
            @(posedge clk);
            cycle++;
            ret = 1'b0;
            if (arst_n && frame_valid) pending.push_back(cycle + 1 + take_bits(3));
            if (!hold_credits && pending.size() != 0 && pending[0] <= cycle) begin
                void'(pending.pop_front());
                ret = 1'b1;
            end
            #1;
            credit_return = ret;
        end
    end

    // Scoreboard and credit checks on every edge
    always @(posedge clk) begin : scoreboard
        ulpi_frame_t e;
        if (arst_n) begin
            if (frame_valid) begin
                assert (exp_q.size() != 0) else begin
                    other_err++;
                    $display("Error at %0t: frame delivered when none was expected", $time);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    check_val("frame_cmd", frame_cmd, e.cmd);
                    check_val("frame_pid", frame_pid, e.pid);
                    check_val("frame_d1", frame_d1, e.d1);
                    check_val("frame_d2", frame_d2, e.d2);
                end
                outstanding++;
            end
            if (credit_return) outstanding--;
            assert (outstanding <= CREDITS) else begin
                other_err++;
                $display("Error at %0t: consumer holds %0d frames, limit %0d",
                         $time, outstanding, CREDITS);
            end
            if (!me && !me_prev) check_val("busy", 8'(busy), 8'd0);  // Held idle
        end
        me_prev = me;
    end

    initial begin : stimulus
        int kind;
        arst_n        = 1'b0;
        me            = 1'b1;
        dir           = 1'b0;
        nxt           = 1'b0;
        data          = 8'h00;
        credit_return = 1'b0;
        hold_credits  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_val("busy", 8'(busy), 8'd0);
        check_val("frame_valid", 8'(frame_valid), 8'd0);
        check_val("drop_count", drop_count, 8'd0);
        repeat (4) step();

        // Mixed good and damaged bursts
        for (int i = 0; i < 40; i++) begin
            kind = take_bits(2);
            kind = (kind < 2) ? 0 : kind - 1;  // Half good
            send_burst(kind, 1'b0);
        end
        drain(200);

        // Queue fills and then overflows while credits are withheld
        hold_credits = 1'b1;
        for (int i = 0; i < CREDITS + QUEUE_DEPTH + 2; i++) begin
            send_burst(0, i >= CREDITS + QUEUE_DEPTH);
        end
        hold_credits = 1'b0;
        drain(200);

        // Disabled mode ignores the bus
        me = 1'b0;
        step();
        for (int i = 0; i < 4; i++) begin
            kind = take_bits(2) % 3;
            send_burst(kind, 1'b0);
        end
        me = 1'b1;
        repeat (2) step();
        send_burst(0, 1'b0);
        drain(200);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_err, other_err);
        if (mismatch_err == 0 && other_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* design/ulpi_rx_top.sv */
// ULPI receive subsystem top level with FSM, capture, frame queue and credit counter
module ulpi_rx_top import ulpi_rx_pkg::*; #(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int CREDITS     = DEF_CREDITS
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       me,
    input  logic       dir,
    input  logic       nxt,
    input  logic [7:0] data,
    input  logic       credit_return,
    output logic       frame_valid,
    output logic [7:0] frame_cmd,
    output logic [7:0] frame_pid,
    output logic [7:0] frame_d1,
    output logic [7:0] frame_d2,
    output logic [7:0] drop_count,
    output logic       busy
);

    logic       dir_q;
    logic       nxt_q;
    logic       load_cmd;
    logic       load_pid;
    logic       load_d1;
    logic       load_d2;
    logic       frame_done;    // Queue write strobe
    logic       frame_abort;   // Drop counter strobe
    logic       queue_full;
    logic       credit_avail;
    logic [7:0] cap_cmd;
    logic [7:0] cap_pid;
    logic [7:0] cap_d1;
    logic [7:0] cap_d2;

    ulpi_rx_fsm i_ulpi_rx_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .me          (me),
        .dir_q       (dir_q),
        .nxt_q       (nxt_q),
        .queue_full  (queue_full),
        .load_cmd    (load_cmd),
        .load_pid    (load_pid),
        .load_d1     (load_d1),
        .load_d2     (load_d2),
        .frame_done  (frame_done),
        .frame_abort (frame_abort),
        .busy        (busy)
    );

    ulpi_frame_capture i_ulpi_frame_capture (
        .clk         (clk),
        .arst_n      (arst_n),
        .dir         (dir),
        .nxt         (nxt),
        .data        (data),
        .load_cmd    (load_cmd),
        .load_pid    (load_pid),
        .load_d1     (load_d1),
        .load_d2     (load_d2),
        .frame_abort (frame_abort),
        .dir_q       (dir_q),
        .nxt_q       (nxt_q),
        .cap_cmd     (cap_cmd),
        .cap_pid     (cap_pid),
        .cap_d1      (cap_d1),
        .cap_d2      (cap_d2),
        .drop_count  (drop_count)
    );

    ulpi_frame_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_ulpi_frame_queue (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr           (frame_done),
        .cap_cmd      (cap_cmd),
        .cap_pid      (cap_pid),
        .cap_d1       (cap_d1),
        .cap_d2       (cap_d2),
        .credit_avail (credit_avail),
        .queue_full   (queue_full),
        .frame_valid  (frame_valid),
        .frame_cmd    (frame_cmd),
        .frame_pid    (frame_pid),
        .frame_d1     (frame_d1),
        .frame_d2     (frame_d2)
    );

    ulpi_credit_counter #(
        .CREDITS (CREDITS)
    ) i_ulpi_credit_counter (
        .clk           (clk),
        .arst_n        (arst_n),
        .frame_valid   (frame_valid),
        .credit_return (credit_return),
        .credit_avail  (credit_avail)
    );

endmodule

/* design/ulpi_credit_counter.sv */
// Consumer credit counter for the frame delivery handshake
module ulpi_credit_counter import ulpi_rx_pkg::*; #(
    parameter int CREDITS = DEF_CREDITS
) (
    input  logic clk,
    input  logic arst_n,
    input  logic frame_valid,    // Consumes one credit
    input  logic credit_return,  // Gives one back
    output logic credit_avail
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count;  // Free credits

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= CNT_W'(CREDITS);  // Consumer starts with all free
        end else begin
            case ({frame_valid, credit_return})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: ;  // Same cycle use and return cancel
            endcase
        end
    end

    assign credit_avail = (count != '0);

    // Consumer returns no more than it was given
    a_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
        count <= CNT_W'(CREDITS))
        else $error("Credit count above CREDITS");

    // Queue only offers a frame against a free credit
    a_no_overdraw: assert property (@(posedge clk) disable iff (!arst_n)
        frame_valid |-> (count != '0))
        else $error("Frame delivered with no credit");

endmodule

/* design/ulpi_frame_queue.sv */
// Frame FIFO that pops one frame per cycle while the consumer has credit
module ulpi_frame_queue import ulpi_rx_pkg::*; #(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr,            // frame_done from the FSM
    input  logic [7:0] cap_cmd,
    input  logic [7:0] cap_pid,
    input  logic [7:0] cap_d1,
    input  logic [7:0] cap_d2,
    input  logic       credit_avail,
    output logic       queue_full,
    output logic       frame_valid,
    output logic [7:0] frame_cmd,
    output logic [7:0] frame_pid,
    output logic [7:0] frame_d1,
    output logic [7:0] frame_d2
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    ulpi_frame_t      mem [QUEUE_DEPTH];
    ulpi_frame_t      wr_frame;
    ulpi_frame_t      rd_frame;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;  // Frames held
    logic             empty;
    logic             push;
    logic             pop;

    // Wrap at the depth, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_frame   = '{cmd: cap_cmd, pid: cap_pid, d1: cap_d1, d2: cap_d2};
    assign empty      = (count == '0);
    assign queue_full = (count == CNT_W'(QUEUE_DEPTH));
    assign push       = wr && !queue_full;
    assign pop        = frame_valid;

    // Head frame offered whenever a credit is free
    assign frame_valid = !empty && credit_avail;
    assign rd_frame    = mem[rd_ptr];
    assign frame_cmd   = rd_frame.cmd;
    assign frame_pid   = rd_frame.pid;
    assign frame_d1    = rd_frame.d1;
    assign frame_d2    = rd_frame.d2;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_frame;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

    // The FSM must turn a completion into a drop when full
    a_no_wr_full: assert property (@(posedge clk) disable iff (!arst_n)
        wr |-> !queue_full)
        else $error("Frame written into a full queue");

endmodule

/* design/ulpi_frame_capture.sv */
// ULPI input register stage, frame byte registers and dropped frame counter
module ulpi_frame_capture import ulpi_rx_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       dir,
    input  logic       nxt,
    input  logic [7:0] data,
    input  logic       load_cmd,
    input  logic       load_pid,
    input  logic       load_d1,
    input  logic       load_d2,
    input  logic       frame_abort,
    output logic       dir_q,
    output logic       nxt_q,
    output logic [7:0] cap_cmd,
    output logic [7:0] cap_pid,
    output logic [7:0] cap_d1,
    output logic [7:0] cap_d2,
    output logic [7:0] drop_count
);

    logic [7:0] data_q;  // Registered bus byte

    // Control half of the bus, cleared so the FSM sees dir low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir_q <= 1'b0;
            nxt_q <= 1'b0;
        end else begin
            dir_q <= dir;
            nxt_q <= nxt;
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data;  // Same edge as dir_q and nxt_q
    end

    // Byte fields, the strobe picks the target
    always_ff @(posedge clk) begin
        if (load_cmd) begin
            cap_cmd <= data_q;  // Both RX CMDs land here, last one stays
        end
        if (load_pid) begin
            cap_pid <= data_q;
        end
        if (load_d1) begin
            cap_d1 <= data_q;
        end
        if (load_d2) begin
            cap_d2 <= data_q;
        end
    end

    // Dropped frames, sticks at the ceiling
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= 8'd0;
        end else if (frame_abort && (drop_count != DROP_MAX)) begin
            drop_count <= drop_count + 8'd1;
        end
    end

endmodule

/* design/ulpi_rx_fsm.sv */
// ULPI receive FSM with byte load strobes and frame done and abort strobes
module ulpi_rx_fsm import ulpi_rx_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic me,          // Mode enable that holds IDLE while low
    input  logic dir_q,       // Registered dir
    input  logic nxt_q,       // Registered nxt
    input  logic queue_full,  // No room for a completed frame
    output logic load_cmd,
    output logic load_pid,
    output logic load_d1,
    output logic load_d2,
    output logic frame_done,
    output logic frame_abort,
    output logic busy
);

    rx_state_t state;
    rx_state_t state_nxt;
    rx_state_t fail_st;     // Where a bad byte sends us
    logic      nxt_exp;     // nxt level expected for the byte on data_q
    logic      byte_ok;     // dir still high and nxt as expected
    logic      in_byte;     // A byte is due on data_q this cycle
    logic      done_nxt;
    logic      abort_nxt;

    // data_q holds the item after the one the state names
    always_comb begin
        load_cmd = 1'b0;
        load_pid = 1'b0;
        load_d1  = 1'b0;
        load_d2  = 1'b0;
        nxt_exp  = NXT_PKT;
        case (state)
            TURN: begin
                load_cmd = 1'b1;  // First RX CMD
                nxt_exp  = NXT_CMD;
            end
            CMD1: load_pid = 1'b1;
            PID:  load_d1  = 1'b1;
            D1: begin
                load_cmd = 1'b1;  // Second RX CMD overwrites the first
                nxt_exp  = NXT_CMD;
            end
            CMD2: load_d2 = 1'b1;
            default: ;
        endcase
    end

    assign in_byte = state inside {TURN, CMD1, PID, D1, CMD2};
    assign byte_ok = dir_q && (nxt_q == nxt_exp);
    // A bad byte with dir still high sits out the rest of the burst in DONE
    assign fail_st = dir_q ? DONE : IDLE;

    always_comb begin
        state_nxt = state;
        done_nxt  = 1'b0;
        abort_nxt = in_byte && !byte_ok;
        case (state)
            IDLE: if (dir_q) state_nxt = TURN;  // Turnaround cycle
            TURN: state_nxt = byte_ok ? CMD1 : fail_st;
            CMD1: state_nxt = byte_ok ? PID  : fail_st;
            PID:  state_nxt = byte_ok ? D1   : fail_st;
            D1:   state_nxt = byte_ok ? CMD2 : fail_st;
            CMD2: state_nxt = byte_ok ? D2   : fail_st;
            D2: begin
                // Full queue turns a good frame into a drop
                done_nxt  = !queue_full;
                abort_nxt = queue_full;
                state_nxt = dir_q ? DONE : IDLE;
            end
            DONE: if (!dir_q) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
        // Disabled mode drops the burst silently
        if (!me) begin
            state_nxt = IDLE;
            done_nxt  = 1'b0;
            abort_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            frame_done  <= 1'b0;
            frame_abort <= 1'b0;
        end else begin
            state       <= state_nxt;
            frame_done  <= done_nxt;   // One cycle pulse
            frame_abort <= abort_nxt;
        end
    end

    assign busy = (state != IDLE);

    // Leaving the burst while enabled always ends in one verdict
    a_one_verdict: assert property (@(posedge clk) disable iff (!arst_n)
        (me && (state inside {TURN, CMD1, PID, D1, CMD2, D2}) &&
         !(state_nxt inside {TURN, CMD1, PID, D1, CMD2, D2}))
        |=> (frame_done ^ frame_abort))
        else $error("FSM left a burst without exactly one of done or abort");

    // Exactly one load strobe in each byte state and none elsewhere
    a_one_load: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({load_cmd, load_pid, load_d1, load_d2}) &&
        (in_byte == (load_cmd || load_pid || load_d1 || load_d2)))
        else $error("Load strobes do not match the byte state");

endmodule

/* design/ulpi_rx_pkg.sv */
// Receiver state type, frame type, bus polarity constants and default sizes
package ulpi_rx_pkg;

    // Receiver states, each names the item already taken from the bus
    typedef enum logic [2:0] {
        IDLE = 3'd0,  // Waiting for dir
        TURN = 3'd1,  // Turnaround seen
        CMD1 = 3'd2,  // First RX CMD taken
        PID  = 3'd3,  // PID byte taken
        D1   = 3'd4,  // First data byte taken
        CMD2 = 3'd5,  // Second RX CMD taken
        D2   = 3'd6,  // Second data byte taken, frame complete
        DONE = 3'd7   // Waiting for dir to fall
    } rx_state_t;

    // One received frame, cmd holds the second RX CMD
    typedef struct packed {
        logic [7:0] cmd;
        logic [7:0] pid;
        logic [7:0] d1;
        logic [7:0] d2;
    } ulpi_frame_t;

    // nxt level the PHY drives with each byte kind
    localparam logic NXT_CMD = 1'b0;  // RX CMD bytes
    localparam logic NXT_PKT = 1'b1;  // Packet bytes

    // Drop counter ceiling
    localparam logic [7:0] DROP_MAX = 8'hff;

    // Default sizing for the top level
    localparam int DEF_QUEUE_DEPTH = 4;
    localparam int DEF_CREDITS     = 2;

endpackage
